//--- include/erase_defs.svh
// Sizing constants for the memory erase subsystem
// Include wherever widths, fraction bits or the lane count are needed

`ifndef ERASE_DEFS_SVH
`define ERASE_DEFS_SVH

// Width of every m, w and e word
`define ERASE_DATA_WIDTH 16

// Fixed point fraction bits, ONE = 1 << 8 = 256
`define ERASE_FRAC_BITS 8

// Number of columns W, one lane per column
`define ERASE_LANES 4

// Row counter and size_n width
`define ERASE_ROW_BITS 8

`endif

//--- memory_erase_top.f
+incdir+include
rtl/erase_pkg.sv
rtl/erase_lane_if.sv
rtl/erase_row_loader.sv
rtl/erase_lane.sv
rtl/erase_row_drainer.sv
rtl/memory_erase_top.sv
verification/memory_erase_sva.sv
verification/memory_erase_tb.sv

//--- rtl/erase_lane.sv
// One erase lane, handles a single column k
// Two stages: keep factor ONE - sat(w*e), then m scaled by keep

`include "erase_defs.svh"

module erase_lane
  import erase_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  erase_lane_if.lane  lane,

  output logic        out_valid,
  output erase_data_t out_m
);

  localparam int unsigned DW = `ERASE_DATA_WIDTH;
  localparam int unsigned FB = `ERASE_FRAC_BITS;

  // Fixed point one, narrow and wide
  localparam erase_data_t       ONE   = erase_data_t'(1 << FB);
  localparam logic [2*DW-1:0]   ONE_W = 1 << FB;

  logic [2*DW-1:0] we_full;
  logic [2*DW-1:0] we_shift;
  erase_data_t     we_sat;
  erase_data_t     keep;
  logic [2*DW-1:0] m_keep_full;

  // Stage one registers
  erase_data_t     keep_q;
  erase_data_t     m_q;
  logic            valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Stage one, keep factor
  ////////////////////////////////////////////////////////////////////////////

  assign we_full  = lane.w * lane.e;
  assign we_shift = we_full >> FB;

  // Clamp at ONE so keep never goes negative
  assign we_sat = (we_shift > ONE_W) ? ONE : we_shift[DW-1:0];
  assign keep   = ONE - we_sat;

  always_ff @(posedge CLK) begin
    keep_q <= keep;
    m_q    <= lane.m;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage two, scaling
  ////////////////////////////////////////////////////////////////////////////

  // keep <= ONE, so the truncated product fits in one word
  assign m_keep_full = m_q * keep_q;

  always_ff @(posedge CLK) begin
    out_m <= m_keep_full[FB +: DW];
  end

  // Valid follows the data through both stages
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      valid_q   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      valid_q   <= lane.valid;
      out_valid <= valid_q;
    end
  end

endmodule

//--- rtl/erase_lane_if.sv
// Row issue bundle from the row loader to a single erase lane
// The loader drives it, the lane only samples it

interface erase_lane_if
  import erase_pkg::*;
();

  // One cycle strobe when a complete row is issued
  logic        valid;

  // Row weight, held while valid is high
  erase_data_t w;

  // Erase value for this column, a level per job
  erase_data_t e;

  // Memory element of this column for the row
  erase_data_t m;

  modport loader (output valid, output w, output e, output m);

  modport lane (input valid, input w, input e, input m);

endinterface

//--- rtl/erase_pkg.sv
// Shared data and counter types for the memory erase RTL and its testbench
// Import with a wildcard import in the module header

`include "erase_defs.svh"

package erase_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data and index types
  ////////////////////////////////////////////////////////////////////////////

  // One element, weight or erase value
  typedef logic [`ERASE_DATA_WIDTH-1:0] erase_data_t;

  // Row counts and row indices
  typedef logic [`ERASE_ROW_BITS-1:0] erase_row_t;

  // Column index, one bit per power of two of lanes
  typedef logic [$clog2(`ERASE_LANES)-1:0] erase_col_t;

endpackage

//--- rtl/erase_row_drainer.sv
// Row drainer for the erase step
// Captures one row of lane results and sends them out one column per cycle
// Counts rows and pulses ready after the last element of the job

`include "erase_defs.svh"

module erase_row_drainer
  import erase_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  input  logic        start,
  input  erase_row_t  size_n,

  // Valid of lane 0, all lanes move in step
  input  logic        lane_valid,
  input  erase_data_t lane_m [`ERASE_LANES],

  output logic        m_out_enable,
  output erase_data_t m_out,
  output erase_row_t  m_out_j,
  output erase_col_t  m_out_k,
  output logic        ready
);

  localparam erase_col_t COL_LAST = erase_col_t'(`ERASE_LANES - 1);

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  // Captured row of results
  erase_data_t cap [`ERASE_LANES];

  // Job size and progress
  erase_row_t  size_q;
  erase_row_t  row_cnt;
  erase_col_t  col_cnt;

  // Row index of the next completed row
  erase_row_t  row_next;

  assign row_next = erase_row_t'(row_cnt + 1'b1);

  ////////////////////////////////////////////////////////////////////////////
  // Capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (lane_valid) begin
      cap <= lane_m;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Serializer and row counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      size_q       <= '0;
      row_cnt      <= '0;
      col_cnt      <= '0;
      m_out_enable <= 1'b0;
      ready        <= 1'b0;
    end else begin
      ready <= 1'b0;

      if (start) begin
        size_q       <= size_n;
        row_cnt      <= '0;
        col_cnt      <= '0;
        m_out_enable <= 1'b0;
      end else if (lane_valid) begin
        // New row captured, start at column 0
        col_cnt      <= '0;
        m_out_enable <= 1'b1;
      end else if (m_out_enable) begin
        if (col_cnt == COL_LAST) begin
          // Row done
          m_out_enable <= 1'b0;
          col_cnt      <= '0;
          row_cnt      <= row_next;
          ready        <= (row_next == size_q);
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end
    end
  end

  // Output word follows the column counter
  assign m_out   = cap[col_cnt];
  assign m_out_k = col_cnt;
  assign m_out_j = row_cnt;

endmodule

//--- rtl/erase_row_loader.sv
// Row loader for the erase step
// Holds the erase vector, gathers one row of m elements behind its w
// and issues the full row to every lane in a single cycle

`include "erase_defs.svh"

module erase_row_loader
  import erase_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  input  logic        start,
  input  logic        e_in_enable,
  input  logic        w_in_enable,
  input  logic        m_in_enable,

  input  erase_data_t e_in,
  input  erase_data_t w_in,
  input  erase_data_t m_in,

  erase_lane_if.loader lanes [`ERASE_LANES]
);

  // Last column index
  localparam erase_col_t COL_LAST = erase_col_t'(`ERASE_LANES - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  // Erase vector, one value per column
  erase_data_t e_reg [`ERASE_LANES];

  // Current row weight and its elements
  erase_data_t w_reg;
  erase_data_t m_buf [`ERASE_LANES];

  // Write pointers
  erase_col_t  e_idx;
  erase_col_t  elem_cnt;

  // Row issue strobe
  logic        row_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      e_idx     <= '0;
      elem_cnt  <= '0;
      row_valid <= 1'b0;
    end else begin
      // Default low, pulse only on the last element
      row_valid <= 1'b0;

      if (start) begin
        e_idx    <= '0;
        elem_cnt <= '0;
      end else begin
        // Erase index wraps after the last column
        if (e_in_enable) begin
          e_idx <= (e_idx == COL_LAST) ? '0 : e_idx + 1'b1;
        end

        // A new w always starts a fresh row
        if (w_in_enable) begin
          elem_cnt <= '0;
        end else if (m_in_enable) begin
          elem_cnt <= (elem_cnt == COL_LAST) ? '0 : elem_cnt + 1'b1;
          // Row complete, issue next cycle
          row_valid <= (elem_cnt == COL_LAST);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (e_in_enable) begin
      e_reg[e_idx] <= e_in;
    end
    if (w_in_enable) begin
      w_reg <= w_in;
    end
    if (m_in_enable) begin
      m_buf[elem_cnt] <= m_in;
    end
  end

  // Fan out to all lanes, each takes its own column
  for (genvar k = 0; k < `ERASE_LANES; k++) begin : g_lane_drive
    assign lanes[k].valid = row_valid;
    assign lanes[k].w     = w_reg;
    assign lanes[k].e     = e_reg[k];
    assign lanes[k].m     = m_buf[k];
  end

endmodule

//--- rtl/memory_erase_top.sv
// Top level of the NTM memory erase step, M(j,k) * (1 - w(j)*e(k))
// Start a job, load e, then stream w plus one row of m per row

`include "erase_defs.svh"

module memory_erase_top
  import erase_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  // Job control
  input  logic        start,
  input  erase_row_t  size_n,
  output logic        ready,

  // Input strobes and data
  input  logic        e_in_enable,
  input  erase_data_t e_in,
  input  logic        w_in_enable,
  input  erase_data_t w_in,
  input  logic        m_in_enable,
  input  erase_data_t m_in,

  // Erased matrix out
  output logic        m_out_enable,
  output erase_data_t m_out,
  output erase_row_t  m_out_j,
  output erase_col_t  m_out_k
);

  ////////////////////////////////////////////////////////////////////////////
  // Wiring
  ////////////////////////////////////////////////////////////////////////////

  // Loader to lanes
  erase_lane_if lane_bus [`ERASE_LANES] ();

  // Lanes to drainer
  logic [`ERASE_LANES-1:0] lane_out_valid;
  erase_data_t             lane_out_m [`ERASE_LANES];

  erase_row_loader row_loader_i (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .e_in_enable (e_in_enable),
    .w_in_enable (w_in_enable),
    .m_in_enable (m_in_enable),
    .e_in        (e_in),
    .w_in        (w_in),
    .m_in        (m_in),
    .lanes       (lane_bus)
  );

  // One lane per column
  for (genvar k = 0; k < `ERASE_LANES; k++) begin : g_lane
    erase_lane lane_i (
      .CLK       (CLK),
      .RST       (RST),
      .lane      (lane_bus[k]),
      .out_valid (lane_out_valid[k]),
      .out_m     (lane_out_m[k])
    );
  end

  erase_row_drainer row_drainer_i (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .size_n       (size_n),
    .lane_valid   (lane_out_valid[0]),
    .lane_m       (lane_out_m),
    .m_out_enable (m_out_enable),
    .m_out        (m_out),
    .m_out_j      (m_out_j),
    .m_out_k      (m_out_k),
    .ready        (ready)
  );

endmodule

//--- verification/memory_erase_sva.sv
// Protocol assertions on the memory erase top level ports
// Attached to memory_erase_top by the bind at the end of this file

`include "erase_defs.svh"

module memory_erase_sva
  import erase_pkg::*;
(
  input logic       CLK,
  input logic       RST,
  input logic       ready,
  input logic       m_out_enable,
  input erase_col_t m_out_k
);

  // ready is a one cycle pulse
  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST) ready |=> !ready)
    else $error("ready stayed high for more than one cycle");

  // Each row starts at column 0
  a_row_first_col: assert property (@(posedge CLK) disable iff (RST)
    $rose(m_out_enable) |-> (m_out_k == '0))
    else $error("row output did not start at column 0");

  // Column steps by one inside a row, the counter width gives the wrap
  a_col_step: assert property (@(posedge CLK) disable iff (RST)
    (m_out_enable && $past(m_out_enable)) |-> (m_out_k == erase_col_t'($past(m_out_k) + 1'b1)))
    else $error("m_out_k did not step by one");

  // Outputs quiet in reset
  a_reset_quiet: assert property (@(posedge CLK) RST |-> (!ready && !m_out_enable))
    else $error("ready or m_out_enable high during reset");

endmodule

bind memory_erase_top memory_erase_sva memory_erase_sva_i (.*);

//--- verification/memory_erase_tb.sv
// Testbench for memory_erase_top
// Loads erase vectors, streams rows and compares every output against a reference model

`include "erase_defs.svh"

module memory_erase_tb
  import erase_pkg::*;
();

  localparam int LANES = `ERASE_LANES;
  localparam int FRAC  = `ERASE_FRAC_BITS;
  localparam int ONE   = 1 << FRAC;

  typedef struct packed {
    erase_data_t v;
    erase_row_t  j;
    erase_col_t  k;
  } exp_t;

  logic CLK, RST, start, ready;
  logic e_in_enable, w_in_enable, m_in_enable, m_out_enable;
  erase_row_t  size_n, m_out_j;
  erase_col_t  m_out_k;
  erase_data_t e_in, w_in, m_in, m_out;

  // Stimulus state
  logic [31:0] lfsr;
  erase_data_t e_vec [LANES];
  erase_data_t m_vec [LANES];
  erase_row_t  next_row, job_size;

  // Scoreboard and monitor state
  exp_t        exp_q [$];
  exp_t        exp_e;
  int          last_m_q [$];
  int          cyc, m_seen, last_out_cyc, ready_cnt, lat_t;
  erase_row_t  last_j;

  memory_erase_top memory_erase_top_i (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and random numbers
  ////////////////////////////////////////////////////////////////////////////

  // M * (1 - sat(w*e)) with every product truncated by FRAC bits
  function automatic erase_data_t erase_ref(input erase_data_t m, w, e);
    longint unsigned we;
    we = (longint'(w) * longint'(e)) >> FRAC;
    if (we > ONE) we = ONE;
    return erase_data_t'((longint'(m) * (ONE - we)) >> FRAC);
  endfunction

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Values up to ONE + ONE/2 so that saturation is reached
  task automatic rand_weight(output erase_data_t x);
    logic [31:0] v;
    take_bits(9, v);
    x = erase_data_t'(v % (ONE + ONE / 2 + 1));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_failure(input string what);
    $display("Error at time %0t: %s", $time, what);
    stop_on_error();
  endtask

  task automatic check_value(input logic [31:0] got, exp, input string msg);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input logic st, e_en, w_en, m_en, input erase_data_t d);
    @(posedge CLK);
    start       <= st;
    e_in_enable <= e_en;
    w_in_enable <= w_en;
    m_in_enable <= m_en;
    e_in        <= d;
    w_in        <= d;
    m_in        <= d;
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, '0);
  endtask

  // One w then the row's m elements with their expected values queued
  task automatic send_row(input erase_data_t w, input int gap);
    drive_cycle(1'b0, 1'b0, 1'b1, 1'b0, w);
    idle(gap);
    for (int k = 0; k < LANES; k++) begin
      drive_cycle(1'b0, 1'b0, 1'b0, 1'b1, m_vec[k]);
      exp_q.push_back('{erase_ref(m_vec[k], w, e_vec[k]), next_row, erase_col_t'(k)});
      idle(gap);
    end
    next_row++;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready !== 1'b1) begin
      @(posedge CLK);
      n++;
      if (n > 400) report_failure("ready never arrived at the end of the job");
    end
  endtask

  // Whole job with fixed or random w and random m
  task automatic run_job(input erase_row_t n, input int gap, input logic fix_w,
                         input erase_data_t w_fix);
    erase_data_t w;
    logic [31:0] v;
    @(posedge CLK);
    start    <= 1'b1;
    size_n   <= n;
    job_size = n;
    next_row = '0;
    for (int k = 0; k < LANES; k++) begin
      drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, e_vec[k]);
      idle(gap);
    end
    // size_n is latched on start and may change afterwards
    size_n <= ~n;
    for (int r = 0; r < n; r++) begin
      for (int k = 0; k < LANES; k++) begin
        take_bits(16, v);
        m_vec[k] = erase_data_t'(v);
      end
      if (fix_w) w = w_fix;
      else rand_weight(w);
      send_row(w, gap);
    end
    idle(1);
    wait_ready();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output compare and timing monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    cyc++;
    if (!RST) begin
      if (start) ready_cnt = 0;
      if (w_in_enable) m_seen = 0;
      if (m_in_enable) begin
        m_seen++;
        // Cycle t of the last element in the row
        if (m_seen == LANES) last_m_q.push_back(cyc);
      end
      if (m_out_enable) begin
        if (exp_q.size() == 0) report_failure("output appeared with nothing expected");
        exp_e = exp_q.pop_front();
        check_value(m_out, exp_e.v, "m_out value");
        check_value(m_out_j, exp_e.j, "m_out_j row index");
        check_value(m_out_k, exp_e.k, "m_out_k column index");
        if (exp_e.k == '0) begin
          lat_t = last_m_q.pop_front();
          check_value(cyc - lat_t, 4, "first output latency after last m_in_enable");
        end
        last_out_cyc = cyc;
        last_j       = m_out_j;
      end
      if (ready) begin
        ready_cnt++;
        if (ready_cnt > 1) report_failure("ready pulsed more than once in one job");
        if (exp_q.size() != 0) report_failure("ready came before all outputs of the job");
        check_value(cyc - last_out_cyc, 1, "ready delay after last output");
        check_value(last_j, job_size - 1'b1, "row of last output before ready");
      end
    end else if (ready === 1'b1 || m_out_enable === 1'b1) begin
      report_failure("ready or m_out_enable high during reset");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST = 1'b1;
    start = 1'b0;
    size_n = '0;
    e_in_enable = 1'b0;
    w_in_enable = 1'b0;
    m_in_enable = 1'b0;
    e_in = '0;
    w_in = '0;
    m_in = '0;
    lfsr = 32'hd580;
    cyc = 0;
    m_seen = 0;
    last_out_cyc = 0;
    ready_cnt = 0;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    idle(2);

    // Identities of the erase rule against the model
    check_value(erase_ref(16'h1234, ONE, '0), 16'h1234, "model with e = 0");
    check_value(erase_ref(16'h1234, ONE, ONE), '0, "model with w = e = ONE");
    check_value(erase_ref(16'h1234, ONE, ONE / 2), 16'h091a, "model with e = ONE/2");

    // e = 0 keeps m
    foreach (e_vec[k]) e_vec[k] = '0;
    run_job(3, 1, 1'b0, '0);
    // Full erase
    foreach (e_vec[k]) e_vec[k] = ONE;
    run_job(3, 1, 1'b1, ONE);
    // Half erase
    foreach (e_vec[k]) e_vec[k] = ONE / 2;
    run_job(3, 1, 1'b1, ONE);
    // Saturation with w*e well above ONE
    foreach (e_vec[k]) e_vec[k] = ONE + ONE / 2;
    run_job(4, 1, 1'b1, ONE + ONE / 2);

    // Random job of 16 rows with gaps
    foreach (e_vec[k]) rand_weight(e_vec[k]);
    run_job(16, 1, 1'b0, '0);
    // Second job with new e and size where rows restart at 0
    foreach (e_vec[k]) rand_weight(e_vec[k]);
    run_job(5, 2, 1'b0, '0);
    // Back to back rows
    foreach (e_vec[k]) rand_weight(e_vec[k]);
    run_job(8, 0, 1'b0, '0);
    idle(4);

    if (exp_q.size() == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1, "outputs missing at the end of the run");
    end
  end

endmodule
